//--- source/cu_cfg_pkg.sv
package cu_cfg_pkg;

    // scalar writeback ports into the integer register file
    localparam int NUM_WB = 2;

    // instructions that can retire in one cycle
    localparam int NUM_RETIRE = 2;

    // graduation list entry index
    localparam int GL_INDEX_W = 6;

    // rename checkpoint id
    localparam int CHKP_W = 2;

    // where fetch takes its next pc from
    typedef enum logic [1:0] {
        NEXT_PC_SEL_BP_OR_PC_4 = 2'b00,
        NEXT_PC_SEL_KEEP_PC    = 2'b01,
        NEXT_PC_SEL_JUMP       = 2'b10
    } next_pc_sel_t;

    // which stage supplies the jump target
    typedef enum logic [1:0] {
        SEL_JUMP_DECODE    = 2'b00,
        SEL_JUMP_EXECUTION = 2'b01,
        SEL_JUMP_CSR       = 2'b10,
        SEL_JUMP_CSR_RW    = 2'b11
    } sel_addr_t;

endpackage

//--- source/cu_stage_pkg.sv
package cu_stage_pkg;

    import cu_cfg_pkg::*;

    // status reported by the pipeline stages

    typedef struct packed {
        logic valid;
        logic valid_jal;
        logic stall_csr_fence;
        logic is_branch;
        logic predicted_as_branch;
    } id_cu_t;

    typedef struct packed {
        logic valid;
        logic is_branch;
        logic out_of_checkpoints;
        logic empty_free_list;
        logic full_iq;
    } ir_cu_t;

    typedef struct packed {
        logic gl_full;
    } rr_cu_t;

    typedef struct packed {
        logic stall;
    } exe_cu_t;

    typedef struct packed {
        logic [NUM_WB-1:0]     valid;
        logic [NUM_WB-1:0]     write_enable;
        logic                  checkpoint_done;
        logic [CHKP_W-1:0]     chkp;
        logic [GL_INDEX_W-1:0] gl_index;
    } wb_cu_t;

    typedef struct packed {
        logic                  valid;
        logic                  xcpt;
        logic                  ecall_taken;
        logic                  stall_csr_fence;
        logic                  fence;
        logic                  fence_i;
        logic                  write_enable;
        logic                  stall_commit;
        logic [NUM_RETIRE-1:0] retire;
        logic [NUM_RETIRE-1:0] regfile_we;
    } commit_cu_t;

    typedef struct packed {
        logic csr_eret;
        logic csr_exception;
        logic csr_stall;
    } csr_cu_t;

    // control sent back to the stages

    typedef struct packed {
        logic      stall_if_1;
        logic      stall_if_2;
        logic      stall_id;
        logic      stall_iq;
        logic      stall_ir;
        logic      stall_rr;
        logic      stall_exe;
        logic      stall_commit;
        sel_addr_t sel_addr_if;
    } pipeline_ctrl_t;

    typedef struct packed {
        logic flush_if;
        logic flush_id;
        logic flush_ir;
        logic flush_rr;
        logic flush_exe;
        logic kill_exe;
        logic flush_commit;
    } pipeline_flush_t;

    typedef struct packed {
        logic                  do_checkpoint;
        logic                  do_recover;
        logic                  delete_checkpoint;
        logic [CHKP_W-1:0]     recover_checkpoint;
        logic [NUM_RETIRE-1:0] enable_commit_update;
        logic                  recover_commit;
    } cu_ir_t;

    typedef struct packed {
        logic [NUM_WB-1:0] write_enable;
    } cu_rr_t;

    typedef struct packed {
        logic                  flush_gl;
        logic [GL_INDEX_W-1:0] flush_gl_index;
    } cu_wb_t;

    typedef struct packed {
        logic flush_gl_commit;
        logic enable_commit;
    } cu_commit_t;

    // shared between the control unit blocks
    typedef struct packed {
        logic xcpt_d;
        logic xcpt_q;
        logic csr_q;
        logic fence_pending;
    } event_state_t;

    typedef struct packed {
        logic mispredict;
        logic confirm;
    } branch_res_t;

endpackage

//--- source/cu_event_state.sv
`timescale 1ns/10ps

module cu_event_state
    import cu_stage_pkg::*;
(
    input  logic         clk_i,
    input  logic         rstn_i,
    input  id_cu_t       id_i,
    input  commit_cu_t   commit_i,
    input  csr_cu_t      csr_i,
    input  logic         flush_fence_i,
    output event_state_t state_o
);

    logic event_seen;
    logic xcpt_d;
    logic csr_d;
    logic xcpt_q;
    logic csr_q;
    logic fence_q;

    // exception, ecall or eret reported this cycle
    assign event_seen = (commit_i.valid && (commit_i.xcpt || commit_i.ecall_taken)) ||
                        csr_i.csr_eret || csr_i.csr_exception;

    // a redirect that fired last cycle may not fire again straight away
    assign xcpt_d = event_seen && !xcpt_q;
    assign csr_d  = commit_i.valid && commit_i.stall_csr_fence && !event_seen && !csr_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            xcpt_q  <= 1'b0;
            csr_q   <= 1'b0;
            fence_q <= 1'b0;
        end else begin
            xcpt_q <= xcpt_d;
            csr_q  <= csr_d;
            // csr or fence seen at decode stays pending until it commits
            if (flush_fence_i) begin
                fence_q <= 1'b0;
            end else if (id_i.valid && id_i.stall_csr_fence) begin
                fence_q <= 1'b1;
            end else if (commit_i.valid && commit_i.stall_csr_fence) begin
                fence_q <= 1'b0;
            end
        end
    end

    assign state_o = '{xcpt_d: xcpt_d, xcpt_q: xcpt_q, csr_q: csr_q, fence_pending: fence_q};

endmodule

//--- source/cu_redirect.sv
`timescale 1ns/10ps

module cu_redirect
    import cu_cfg_pkg::*;
    import cu_stage_pkg::*;
(
    input  logic            correct_branch_pred_i,
    input  id_cu_t          id_i,
    input  ir_cu_t          ir_i,
    input  rr_cu_t          rr_i,
    input  exe_cu_t         exe_i,
    input  wb_cu_t          wb_i,
    input  commit_cu_t      commit_i,
    input  csr_cu_t         csr_i,
    input  event_state_t    state_i,
    input  logic            stall_if_1_i,
    output next_pc_sel_t    next_pc_o,
    output sel_addr_t       sel_addr_o,
    output pipeline_flush_t flush_o,
    output logic            flush_fence_o,
    output logic            invalidate_icache_o,
    output logic            invalidate_buffer_o,
    output branch_res_t     branch_o,
    output cu_wb_t          cu_wb_o
);

    logic mispredict;
    logic bad_pred;
    logic redirect_q;
    logic jump;
    logic keep_pc;

    // branch resolved at writeback port 0
    assign mispredict = wb_i.valid[0] && !correct_branch_pred_i;
    assign branch_o   = '{mispredict: mispredict,
                          confirm:    wb_i.valid[0] && correct_branch_pred_i};

    // decode found a predicted taken on something that is not a branch
    assign bad_pred   = id_i.valid && !id_i.is_branch && id_i.predicted_as_branch;
    assign redirect_q = state_i.xcpt_q || state_i.csr_q;
    assign jump       = mispredict || bad_pred || id_i.valid_jal || redirect_q;
    assign keep_pc    = stall_if_1_i || (id_i.valid && id_i.stall_csr_fence) ||
                        state_i.fence_pending || (commit_i.valid && commit_i.fence);

    always_comb begin
        if (jump) begin
            next_pc_o = NEXT_PC_SEL_JUMP;
        end else if (keep_pc) begin
            next_pc_o = NEXT_PC_SEL_KEEP_PC;
        end else begin
            next_pc_o = NEXT_PC_SEL_BP_OR_PC_4;
        end
    end

    always_comb begin
        if (state_i.xcpt_q) begin
            sel_addr_o = SEL_JUMP_CSR;
        end else if (state_i.csr_q) begin
            sel_addr_o = SEL_JUMP_CSR_RW;
        end else if (mispredict) begin
            sel_addr_o = SEL_JUMP_EXECUTION;
        end else begin
            sel_addr_o = SEL_JUMP_DECODE;
        end
    end

    always_comb begin
        flush_o       = '0;
        flush_fence_o = 1'b0;
        // front end
        if (redirect_q || mispredict) begin
            flush_o.flush_if = 1'b1;
            flush_o.flush_id = 1'b1;
        end else if (!csr_i.csr_stall) begin
            // only the fetch slot refills behind these
            flush_o.flush_if = id_i.stall_csr_fence || state_i.fence_pending ||
                               commit_i.stall_csr_fence || id_i.valid_jal ||
                               (commit_i.valid && commit_i.fence) || bad_pred;
        end
        // back end
        if (state_i.xcpt_q) begin
            flush_o.flush_ir     = 1'b1;
            flush_o.flush_rr     = 1'b1;
            flush_o.flush_exe    = 1'b1;
            flush_o.flush_commit = 1'b1;
            flush_fence_o        = 1'b1;
        end else if (mispredict) begin
            // execute keeps older work, the wrong path is killed
            flush_o.flush_ir = 1'b1;
            flush_o.flush_rr = 1'b1;
            flush_o.kill_exe = 1'b1;
            flush_fence_o    = 1'b1;
        end else if (exe_i.stall) begin
            // held stages keep their contents
        end else if (rr_i.gl_full) begin
            flush_o.flush_rr = 1'b1;
        end
    end

    // fence_i may follow self-modifying code
    assign invalidate_icache_o = commit_i.valid && commit_i.fence_i;
    assign invalidate_buffer_o = commit_i.valid &&
                                 (commit_i.fence_i || state_i.xcpt_q ||
                                  (commit_i.stall_csr_fence && !commit_i.fence));

    // drop everything younger than the mispredicted entry
    assign cu_wb_o = '{flush_gl:       mispredict,
                       flush_gl_index: mispredict ? wb_i.gl_index : {GL_INDEX_W{1'b0}}};

endmodule

//--- source/cu_stall.sv
`timescale 1ns/10ps

module cu_stall
    import cu_cfg_pkg::*;
    import cu_stage_pkg::*;
(
    input  logic           miss_icache_i,
    input  logic           ready_icache_i,
    input  ir_cu_t         ir_i,
    input  rr_cu_t         rr_i,
    input  exe_cu_t        exe_i,
    input  commit_cu_t     commit_i,
    input  csr_cu_t        csr_i,
    output pipeline_ctrl_t ctrl_o
);

    always_comb begin
        ctrl_o = '0;
        // fetch address is picked by the redirect logic
        ctrl_o.sel_addr_if  = SEL_JUMP_DECODE;
        ctrl_o.stall_commit = commit_i.stall_commit;

        // front end
        if (csr_i.csr_stall || ir_i.full_iq) begin
            ctrl_o.stall_if_1 = 1'b1;
            ctrl_o.stall_if_2 = 1'b1;
            ctrl_o.stall_id   = 1'b1;
        end else if (miss_icache_i) begin
            ctrl_o.stall_if_1 = 1'b1;
            ctrl_o.stall_if_2 = 1'b1;
        end else if ((commit_i.valid && commit_i.stall_csr_fence) || !ready_icache_i) begin
            ctrl_o.stall_if_1 = 1'b1;
        end

        // back end
        if (csr_i.csr_stall) begin
            ctrl_o.stall_iq  = 1'b1;
            ctrl_o.stall_ir  = 1'b1;
            ctrl_o.stall_rr  = 1'b1;
            ctrl_o.stall_exe = 1'b1;
        end else if (exe_i.stall || rr_i.gl_full) begin
            // execute keeps running so the blockage can drain
            ctrl_o.stall_iq = 1'b1;
            ctrl_o.stall_ir = 1'b1;
            ctrl_o.stall_rr = 1'b1;
        end else if (ir_i.empty_free_list || ir_i.out_of_checkpoints) begin
            ctrl_o.stall_iq = 1'b1;
        end
    end

endmodule

//--- source/cu_rename_ctrl.sv
`timescale 1ns/10ps

module cu_rename_ctrl
    import cu_cfg_pkg::*;
    import cu_stage_pkg::*;
(
    input  ir_cu_t       ir_i,
    input  wb_cu_t       wb_i,
    input  commit_cu_t   commit_i,
    input  event_state_t state_i,
    input  branch_res_t  branch_i,
    input  logic         flush_ir_i,
    input  logic         stall_ir_i,
    output cu_ir_t       cu_ir_o,
    output cu_commit_t   cu_commit_o
);

    always_comb begin
        // snapshot rename state for a branch that really leaves rename
        cu_ir_o.do_checkpoint = ir_i.valid && ir_i.is_branch && !ir_i.out_of_checkpoints &&
                                !flush_ir_i && !stall_ir_i;

        // resolved branches release or restore their checkpoint
        cu_ir_o.do_recover         = branch_i.mispredict && wb_i.checkpoint_done;
        cu_ir_o.delete_checkpoint  = branch_i.confirm && wb_i.checkpoint_done;
        cu_ir_o.recover_checkpoint = wb_i.chkp;

        // no free list update from instructions squashed by an exception
        cu_ir_o.enable_commit_update = commit_i.retire & commit_i.regfile_we &
                                       {NUM_RETIRE{!state_i.xcpt_d}};
        cu_ir_o.recover_commit = state_i.xcpt_q;

        cu_commit_o.flush_gl_commit = state_i.xcpt_q;
        cu_commit_o.enable_commit   = !commit_i.stall_commit && !state_i.xcpt_d;
    end

endmodule

//--- source/cu_regfile_wr.sv
`timescale 1ns/10ps

module cu_regfile_wr
    import cu_cfg_pkg::*;
    import cu_stage_pkg::*;
(
    input  wb_cu_t     wb_i,
    input  commit_cu_t commit_i,
    input  csr_cu_t    csr_i,
    output cu_rr_t     cu_rr_o
);

    always_comb begin
        for (int i = 0; i < NUM_WB; i++) begin
            cu_rr_o.write_enable[i] = wb_i.valid[i] && wb_i.write_enable[i];
        end
        // port 0 also carries the commit-time write (csr results)
        if (commit_i.valid && !commit_i.xcpt && !csr_i.csr_exception &&
            commit_i.write_enable) begin
            cu_rr_o.write_enable[0] = 1'b1;
        end
    end

endmodule

//--- source/control_unit.sv
`timescale 1ns/10ps

module control_unit
    import cu_cfg_pkg::*;
    import cu_stage_pkg::*;
(
    input  logic            clk_i,
    input  logic            rstn_i,
    input  logic            miss_icache_i,
    input  logic            ready_icache_i,
    input  logic            correct_branch_pred_i,
    input  id_cu_t          id_cu_i,
    input  ir_cu_t          ir_cu_i,
    input  rr_cu_t          rr_cu_i,
    input  exe_cu_t         exe_cu_i,
    input  wb_cu_t          wb_cu_i,
    input  commit_cu_t      commit_cu_i,
    input  csr_cu_t         csr_cu_i,
    output pipeline_ctrl_t  pipeline_ctrl_o,
    output pipeline_flush_t pipeline_flush_o,
    output next_pc_sel_t    next_pc_o,
    output logic            invalidate_icache_o,
    output logic            invalidate_buffer_o,
    output cu_ir_t          cu_ir_o,
    output cu_rr_t          cu_rr_o,
    output cu_wb_t          cu_wb_o,
    output cu_commit_t      cu_commit_o
);

    event_state_t   state;
    branch_res_t    branch;
    pipeline_ctrl_t stall_ctrl;
    sel_addr_t      sel_addr;
    logic           flush_fence;

    cu_event_state u_event_state (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .id_i          (id_cu_i),
        .commit_i      (commit_cu_i),
        .csr_i         (csr_cu_i),
        .flush_fence_i (flush_fence),
        .state_o       (state)
    );

    cu_redirect u_redirect (
        .correct_branch_pred_i (correct_branch_pred_i),
        .id_i                  (id_cu_i),
        .ir_i                  (ir_cu_i),
        .rr_i                  (rr_cu_i),
        .exe_i                 (exe_cu_i),
        .wb_i                  (wb_cu_i),
        .commit_i              (commit_cu_i),
        .csr_i                 (csr_cu_i),
        .state_i               (state),
        .stall_if_1_i          (stall_ctrl.stall_if_1),
        .next_pc_o             (next_pc_o),
        .sel_addr_o            (sel_addr),
        .flush_o               (pipeline_flush_o),
        .flush_fence_o         (flush_fence),
        .invalidate_icache_o   (invalidate_icache_o),
        .invalidate_buffer_o   (invalidate_buffer_o),
        .branch_o              (branch),
        .cu_wb_o               (cu_wb_o)
    );

    cu_stall u_stall (
        .miss_icache_i  (miss_icache_i),
        .ready_icache_i (ready_icache_i),
        .ir_i           (ir_cu_i),
        .rr_i           (rr_cu_i),
        .exe_i          (exe_cu_i),
        .commit_i       (commit_cu_i),
        .csr_i          (csr_cu_i),
        .ctrl_o         (stall_ctrl)
    );

    cu_rename_ctrl u_rename_ctrl (
        .ir_i        (ir_cu_i),
        .wb_i        (wb_cu_i),
        .commit_i    (commit_cu_i),
        .state_i     (state),
        .branch_i    (branch),
        .flush_ir_i  (pipeline_flush_o.flush_ir),
        .stall_ir_i  (stall_ctrl.stall_ir),
        .cu_ir_o     (cu_ir_o),
        .cu_commit_o (cu_commit_o)
    );

    cu_regfile_wr u_regfile_wr (
        .wb_i     (wb_cu_i),
        .commit_i (commit_cu_i),
        .csr_i    (csr_cu_i),
        .cu_rr_o  (cu_rr_o)
    );

    // stall levels plus the fetch address chosen by the redirect block
    always_comb begin
        pipeline_ctrl_o             = stall_ctrl;
        pipeline_ctrl_o.sel_addr_if = sel_addr;
    end

endmodule

//--- include/cu_ref_model.svh
`ifndef CU_REF_MODEL_SVH
`define CU_REF_MODEL_SVH

// included inside a module that imports cu_cfg_pkg and cu_stage_pkg

typedef struct packed {
    pipeline_ctrl_t  ctrl;
    pipeline_flush_t flush;
    next_pc_sel_t    next_pc;
    logic            inv_icache;
    logic            inv_buffer;
    cu_ir_t          cu_ir;
    cu_rr_t          cu_rr;
    cu_wb_t          cu_wb;
    cu_commit_t      cu_commit;
} cu_expect_t;

// expected outputs for one cycle; st.xcpt_d is recomputed here
function automatic cu_expect_t cu_ref_outputs(
    input logic         miss,
    input logic         ready,
    input logic         correct,
    input id_cu_t       id,
    input ir_cu_t       ir,
    input rr_cu_t       rr,
    input exe_cu_t      exe,
    input wb_cu_t       wb,
    input commit_cu_t   c,
    input csr_cu_t      csr,
    input event_state_t st
);
    cu_expect_t e;
    logic       xd;
    logic       mis;
    logic       bad;
    logic       jmp;
    logic       keep;
    xd  = !st.xcpt_q && ((c.valid && (c.xcpt || c.ecall_taken)) || csr.csr_eret ||
                         csr.csr_exception);
    mis = wb.valid[0] && !correct;
    bad = id.valid && !id.is_branch && id.predicted_as_branch;
    e   = '0;
    // stalls as flat equations of the priority chains
    e.ctrl.stall_if_1   = csr.csr_stall || ir.full_iq || miss ||
                          (c.valid && c.stall_csr_fence) || !ready;
    e.ctrl.stall_if_2   = csr.csr_stall || ir.full_iq || miss;
    e.ctrl.stall_id     = csr.csr_stall || ir.full_iq;
    e.ctrl.stall_iq     = csr.csr_stall || exe.stall || rr.gl_full || ir.empty_free_list ||
                          ir.out_of_checkpoints;
    e.ctrl.stall_ir     = csr.csr_stall || exe.stall || rr.gl_full;
    e.ctrl.stall_rr     = e.ctrl.stall_ir;
    e.ctrl.stall_exe    = csr.csr_stall;
    e.ctrl.stall_commit = c.stall_commit;
    e.ctrl.sel_addr_if  = st.xcpt_q ? SEL_JUMP_CSR : st.csr_q ? SEL_JUMP_CSR_RW :
                          mis ? SEL_JUMP_EXECUTION : SEL_JUMP_DECODE;
    jmp  = mis || bad || id.valid_jal || st.xcpt_q || st.csr_q;
    keep = e.ctrl.stall_if_1 || (id.valid && id.stall_csr_fence) || st.fence_pending ||
           (c.valid && c.fence);
    e.next_pc = jmp ? NEXT_PC_SEL_JUMP : keep ? NEXT_PC_SEL_KEEP_PC : NEXT_PC_SEL_BP_OR_PC_4;
    e.flush.flush_id     = st.xcpt_q || st.csr_q || mis;
    e.flush.flush_if     = e.flush.flush_id || (!csr.csr_stall &&
                           (id.stall_csr_fence || st.fence_pending || c.stall_csr_fence ||
                            id.valid_jal || (c.valid && c.fence) || bad));
    e.flush.flush_ir     = st.xcpt_q || mis;
    e.flush.flush_rr     = st.xcpt_q || mis || (!exe.stall && rr.gl_full);
    e.flush.flush_exe    = st.xcpt_q;
    e.flush.kill_exe     = !st.xcpt_q && mis;
    e.flush.flush_commit = st.xcpt_q;
    e.inv_icache = c.valid && c.fence_i;
    e.inv_buffer = c.valid && (c.fence_i || st.xcpt_q || (c.stall_csr_fence && !c.fence));
    e.cu_ir.do_checkpoint        = ir.valid && ir.is_branch && !ir.out_of_checkpoints &&
                                   !e.flush.flush_ir && !e.ctrl.stall_ir;
    e.cu_ir.do_recover           = mis && wb.checkpoint_done;
    e.cu_ir.delete_checkpoint    = wb.valid[0] && correct && wb.checkpoint_done;
    e.cu_ir.recover_checkpoint   = wb.chkp;
    e.cu_ir.enable_commit_update = c.retire & c.regfile_we & {NUM_RETIRE{!xd}};
    e.cu_ir.recover_commit       = st.xcpt_q;
    e.cu_rr.write_enable = wb.valid & wb.write_enable;
    e.cu_rr.write_enable[0] |= c.valid && !c.xcpt && !csr.csr_exception && c.write_enable;
    e.cu_wb.flush_gl       = mis;
    e.cu_wb.flush_gl_index = mis ? wb.gl_index : '0;
    e.cu_commit.flush_gl_commit = st.xcpt_q;
    e.cu_commit.enable_commit   = !c.stall_commit && !xd;
    return e;
endfunction

`endif

//--- testbench/tb_control_unit.sv
`timescale 1ns/10ps

module tb_control_unit
    import cu_cfg_pkg::*;
    import cu_stage_pkg::*;
();

    localparam int RANDOM_CYCLES = 400;
    localparam int WAIT_LIMIT    = 8;

    logic            clk_i;
    logic            rstn_i;
    logic            miss_icache_i;
    logic            ready_icache_i;
    logic            correct_branch_pred_i;
    id_cu_t          id_cu_i;
    ir_cu_t          ir_cu_i;
    rr_cu_t          rr_cu_i;
    exe_cu_t         exe_cu_i;
    wb_cu_t          wb_cu_i;
    commit_cu_t      commit_cu_i;
    csr_cu_t         csr_cu_i;
    pipeline_ctrl_t  pipeline_ctrl_o;
    pipeline_flush_t pipeline_flush_o;
    next_pc_sel_t    next_pc_o;
    logic            invalidate_icache_o;
    logic            invalidate_buffer_o;
    cu_ir_t          cu_ir_o;
    cu_rr_t          cu_rr_o;
    cu_wb_t          cu_wb_o;
    cu_commit_t      cu_commit_o;

    // testbench copy of the three state bits
    event_state_t st;
    int           errors;
    int           checks;
    int           driven;
    logic         timed_out;

    control_unit DUT (
        .clk_i                 (clk_i),
        .rstn_i                (rstn_i),
        .miss_icache_i         (miss_icache_i),
        .ready_icache_i        (ready_icache_i),
        .correct_branch_pred_i (correct_branch_pred_i),
        .id_cu_i               (id_cu_i),
        .ir_cu_i               (ir_cu_i),
        .rr_cu_i               (rr_cu_i),
        .exe_cu_i              (exe_cu_i),
        .wb_cu_i               (wb_cu_i),
        .commit_cu_i           (commit_cu_i),
        .csr_cu_i              (csr_cu_i),
        .pipeline_ctrl_o       (pipeline_ctrl_o),
        .pipeline_flush_o      (pipeline_flush_o),
        .next_pc_o             (next_pc_o),
        .invalidate_icache_o   (invalidate_icache_o),
        .invalidate_buffer_o   (invalidate_buffer_o),
        .cu_ir_o               (cu_ir_o),
        .cu_rr_o               (cu_rr_o),
        .cu_wb_o               (cu_wb_o),
        .cu_commit_o           (cu_commit_o)
    );

    `include "cu_ref_model.svh"

    always #50 clk_i = !clk_i;

    // true about once in n calls
    function automatic logic rare(input int unsigned n);
        return ($urandom % n) == 0;
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, want);
        errors++;
    endtask

    // inputs change a little after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        driven++;
    endtask

    task automatic set_quiet();
        miss_icache_i         = 1'b0;
        ready_icache_i        = 1'b1;
        correct_branch_pred_i = 1'b0;
        id_cu_i               = '0;
        ir_cu_i               = '0;
        rr_cu_i               = '0;
        exe_cu_i              = '0;
        wb_cu_i               = '0;
        commit_cu_i           = '0;
        csr_cu_i              = '0;
    endtask

    // event bits kept rare so redirect windows open now and then
    task automatic drive_random();
        miss_icache_i                = rare(8);
        ready_icache_i               = !rare(8);
        correct_branch_pred_i        = $urandom_range(1);
        id_cu_i.valid                = $urandom_range(1);
        id_cu_i.valid_jal            = rare(8);
        id_cu_i.stall_csr_fence      = rare(16);
        id_cu_i.is_branch            = $urandom_range(1);
        id_cu_i.predicted_as_branch  = rare(4);
        ir_cu_i.valid                = $urandom_range(1);
        ir_cu_i.is_branch            = $urandom_range(1);
        ir_cu_i.out_of_checkpoints   = rare(6);
        ir_cu_i.empty_free_list      = rare(6);
        ir_cu_i.full_iq              = rare(6);
        rr_cu_i.gl_full              = rare(6);
        exe_cu_i.stall               = rare(6);
        wb_cu_i.valid                = $urandom_range(3);
        wb_cu_i.write_enable         = $urandom_range(3);
        wb_cu_i.checkpoint_done      = $urandom_range(1);
        wb_cu_i.chkp                 = $urandom_range(3);
        wb_cu_i.gl_index             = $urandom_range(63);
        commit_cu_i.valid            = $urandom_range(1);
        commit_cu_i.xcpt             = rare(16);
        commit_cu_i.ecall_taken      = rare(32);
        commit_cu_i.stall_csr_fence  = rare(12);
        commit_cu_i.fence            = rare(12);
        commit_cu_i.fence_i          = rare(16);
        commit_cu_i.write_enable     = $urandom_range(1);
        commit_cu_i.stall_commit     = rare(4);
        commit_cu_i.retire           = $urandom_range(3);
        commit_cu_i.regfile_we       = $urandom_range(3);
        csr_cu_i.csr_eret            = rare(32);
        csr_cu_i.csr_exception       = rare(32);
        csr_cu_i.csr_stall           = rare(10);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk_i) begin : compare_outputs
        cu_expect_t want;
        logic       ev;
        logic       flush_fence;
        if (rstn_i) begin
            want = cu_ref_outputs(miss_icache_i, ready_icache_i, correct_branch_pred_i,
                                  id_cu_i, ir_cu_i, rr_cu_i, exe_cu_i, wb_cu_i,
                                  commit_cu_i, csr_cu_i, st);
            checks++;
            if (pipeline_ctrl_o !== want.ctrl) begin
                report_mismatch("pipeline_ctrl_o", pipeline_ctrl_o, want.ctrl);
            end
            if (pipeline_flush_o !== want.flush) begin
                report_mismatch("pipeline_flush_o", pipeline_flush_o, want.flush);
            end
            if (next_pc_o !== want.next_pc) begin
                report_mismatch("next_pc_o", next_pc_o, want.next_pc);
            end
            if (invalidate_icache_o !== want.inv_icache) begin
                report_mismatch("invalidate_icache_o", invalidate_icache_o, want.inv_icache);
            end
            if (invalidate_buffer_o !== want.inv_buffer) begin
                report_mismatch("invalidate_buffer_o", invalidate_buffer_o, want.inv_buffer);
            end
            if (cu_ir_o !== want.cu_ir) begin
                report_mismatch("cu_ir_o", cu_ir_o, want.cu_ir);
            end
            if (cu_rr_o !== want.cu_rr) begin
                report_mismatch("cu_rr_o", cu_rr_o, want.cu_rr);
            end
            if (cu_wb_o !== want.cu_wb) begin
                report_mismatch("cu_wb_o", cu_wb_o, want.cu_wb);
            end
            if (cu_commit_o !== want.cu_commit) begin
                report_mismatch("cu_commit_o", cu_commit_o, want.cu_commit);
            end

            // state seen by the DUT after the coming edge
            ev = (commit_cu_i.valid && (commit_cu_i.xcpt || commit_cu_i.ecall_taken)) ||
                 csr_cu_i.csr_eret || csr_cu_i.csr_exception;
            flush_fence = st.xcpt_q || (wb_cu_i.valid[0] && !correct_branch_pred_i);
            if (flush_fence) begin
                st.fence_pending = 1'b0;
            end else if (id_cu_i.valid && id_cu_i.stall_csr_fence) begin
                st.fence_pending = 1'b1;
            end else if (commit_cu_i.valid && commit_cu_i.stall_csr_fence) begin
                st.fence_pending = 1'b0;
            end
            st.csr_q  = commit_cu_i.valid && commit_cu_i.stall_csr_fence && !ev && !st.csr_q;
            st.xcpt_q = ev && !st.xcpt_q;
        end
    end

    initial begin : main_sequence
        int unsigned seed;
        int          waited;
        logic        seen;
        seed = 32'hdb06de9f;
        void'($urandom(seed));
        errors    = 0;
        checks    = 0;
        driven    = 0;
        timed_out = 1'b0;
        st        = '0;
        clk_i     = 1'b0;
        rstn_i    = 1'b0;
        set_quiet();
        repeat (9) @(posedge clk_i);
        next_cycle();
        rstn_i = 1'b1;

        // quiet pipeline right after reset
        next_cycle();
        set_quiet();
        @(negedge clk_i);
        if (pipeline_ctrl_o !== '0) begin
            report_mismatch("pipeline_ctrl_o", pipeline_ctrl_o, 0);
        end
        if (pipeline_flush_o !== '0) begin
            report_mismatch("pipeline_flush_o", pipeline_flush_o, 0);
        end
        if (next_pc_o !== NEXT_PC_SEL_BP_OR_PC_4) begin
            report_mismatch("next_pc_o", next_pc_o, NEXT_PC_SEL_BP_OR_PC_4);
        end

        // mispredict at writeback port 0
        next_cycle();
        set_quiet();
        wb_cu_i.valid           = 2'b01;
        wb_cu_i.checkpoint_done = 1'b1;
        wb_cu_i.chkp            = 2'd3;
        wb_cu_i.gl_index        = 6'h2a;
        @(negedge clk_i);
        if (next_pc_o !== NEXT_PC_SEL_JUMP) begin
            report_mismatch("next_pc_o", next_pc_o, NEXT_PC_SEL_JUMP);
        end
        if (cu_wb_o.flush_gl_index !== 6'h2a) begin
            report_mismatch("cu_wb_o.flush_gl_index", cu_wb_o.flush_gl_index, 6'h2a);
        end

        // commit exception, redirect expected one cycle later
        next_cycle();
        set_quiet();
        commit_cu_i.valid = 1'b1;
        commit_cu_i.xcpt  = 1'b1;
        @(negedge clk_i);
        if (cu_commit_o.enable_commit !== 1'b0) begin
            report_mismatch("cu_commit_o.enable_commit", cu_commit_o.enable_commit, 0);
        end
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < WAIT_LIMIT) begin
            next_cycle();
            set_quiet();
            @(negedge clk_i);
            waited++;
            seen = cu_commit_o.flush_gl_commit;
        end
        if (!seen) begin
            $display("flush_gl_commit never followed the commit exception");
            errors++;
        end else if (waited != 1) begin
            $display("flush_gl_commit came %0d cycles after the exception, not 1", waited);
            errors++;
        end
        if (pipeline_ctrl_o.sel_addr_if !== SEL_JUMP_CSR) begin
            report_mismatch("pipeline_ctrl_o.sel_addr_if", pipeline_ctrl_o.sel_addr_if,
                            SEL_JUMP_CSR);
        end
        next_cycle();
        set_quiet();
        @(negedge clk_i);
        if (cu_commit_o.flush_gl_commit !== 1'b0) begin
            report_mismatch("cu_commit_o.flush_gl_commit", cu_commit_o.flush_gl_commit, 0);
        end

        // csr at decode holds fetch until it commits
        next_cycle();
        set_quiet();
        id_cu_i.valid           = 1'b1;
        id_cu_i.stall_csr_fence = 1'b1;
        repeat (3) begin
            next_cycle();
            set_quiet();
            @(negedge clk_i);
            if (next_pc_o !== NEXT_PC_SEL_KEEP_PC) begin
                report_mismatch("next_pc_o", next_pc_o, NEXT_PC_SEL_KEEP_PC);
            end
            if (pipeline_flush_o.flush_if !== 1'b1) begin
                report_mismatch("pipeline_flush_o.flush_if", pipeline_flush_o.flush_if, 1);
            end
        end
        next_cycle();
        set_quiet();
        commit_cu_i.valid           = 1'b1;
        commit_cu_i.stall_csr_fence = 1'b1;
        next_cycle();
        set_quiet();
        commit_cu_i.valid   = 1'b1;
        commit_cu_i.fence_i = 1'b1;
        @(negedge clk_i);
        if (invalidate_icache_o !== 1'b1) begin
            report_mismatch("invalidate_icache_o", invalidate_icache_o, 1);
        end
        if (invalidate_buffer_o !== 1'b1) begin
            report_mismatch("invalidate_buffer_o", invalidate_buffer_o, 1);
        end

        repeat (RANDOM_CYCLES) begin
            next_cycle();
            drive_random();
        end
        next_cycle();
        set_quiet();

        waited = 0;
        while (checks < driven && waited < WAIT_LIMIT) begin
            @(posedge clk_i);
            waited++;
        end
        if (checks < driven) begin
            $display("compare process did not catch up with the stimulus");
            timed_out = 1'b1;
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+include
source/cu_cfg_pkg.sv
source/cu_stage_pkg.sv
source/cu_event_state.sv
source/cu_redirect.sv
source/cu_stall.sv
source/cu_rename_ctrl.sv
source/cu_regfile_wr.sv
source/control_unit.sv
testbench/tb_control_unit.sv
